// ==== Bender.yml ====
package:
  name: fetch

sources:
  - files:
      - design/fetch_pkg.sv
      - design/ifu.sv
      - design/inst_mem.sv
      - design/next_pc.sv
      - design/fetch_top.sv
  - target: test
    files:
      - verification/fetch_props.sv
      - verification/fetch_tb.sv

// ==== design/fetch_pkg.sv ====
`default_nettype none

package fetch_pkg;

	// core and bus widths
	localparam int xlen = 64;
	localparam int addr_w = 32;
	localparam int data_w = 64;
	localparam int inst_w = 32;

	// reset vector, also where a fetch error traps to
	localparam logic [xlen-1:0] reset_pc = 64'h0000_0000_8000_0000;

	// instruction memory geometry
	// window starts at the reset vector
	localparam int mem_words = 256;
	localparam int mem_idx_w = $clog2(mem_words);
	// byte offset width across the whole window
	localparam int mem_off_w = mem_idx_w + 3;
	localparam logic [addr_w-1:0] mem_base = reset_pc[addr_w-1:0];

	// cycles from address accept to read data valid
	// counter in inst_mem assumes at least 2
	localparam int mem_latency = 2;
	localparam int lat_cnt_w = $clog2(mem_latency + 1);

	// read response codes
	localparam logic [1:0] resp_okay = 2'b00;
	localparam logic [1:0] resp_slverr = 2'b10;

	// control flow opcodes
	localparam logic [6:0] op_jal = 7'b1101111;
	localparam logic [6:0] op_jalr = 7'b1100111;

	// one instruction word, two field layouts
	typedef union packed {
		// j-type
		// immediate bits land scattered across the word
		struct packed {
			logic       imm_20;
			logic [9:0] imm_10_1;
			logic       imm_11;
			logic [7:0] imm_19_12;
			logic [4:0] rd;
			logic [6:0] opcode;
		} j_fmt;
		// i-type
		struct packed {
			logic [11:0] imm_11_0;
			logic [4:0]  rs1;
			logic [2:0]  funct3;
			logic [4:0]  rd;
			logic [6:0]  opcode;
		} i_fmt;
	} rv_inst_u;

endpackage

`default_nettype wire

// ==== design/fetch_top.sv ====
`default_nettype none

module fetch_top (
	input  wire                              clk,
	input  wire                              arst_n,
	input  wire                              hold,
	input  wire                              load_en,
	input  wire  [fetch_pkg::mem_idx_w-1:0]  load_addr,
	input  wire  [fetch_pkg::data_w-1:0]     load_data,
	output logic                             retire_valid,
	output logic [fetch_pkg::xlen-1:0]       retire_pc,
	output logic [fetch_pkg::inst_w-1:0]     retire_inst,
	output logic                             retire_err
);
	import fetch_pkg::*;

	// read address channel
	logic arvalid;
	logic [addr_w-1:0] araddr;
	logic arready;

	// read data channel
	logic rvalid;
	logic [data_w-1:0] rdata;
	logic [1:0] rresp;
	logic rready;

	// fetch result and redirect
	logic inst_valid;
	logic [inst_w-1:0] inst;
	logic [xlen-1:0] pc;
	logic fetch_err;
	logic pc_update;
	logic [xlen-1:0] dnpc;

	ifu ifu_inst (
		.clk        (clk),
		.arst_n     (arst_n),
		.dnpc       (dnpc),
		.pc_update  (pc_update),
		.pc         (pc),
		.arvalid    (arvalid),
		.araddr     (araddr),
		.arready    (arready),
		.rvalid     (rvalid),
		.rdata      (rdata),
		.rresp      (rresp),
		.rready     (rready),
		.inst_valid (inst_valid),
		.inst       (inst),
		.fetch_err  (fetch_err)
	);

	inst_mem inst_mem_inst (
		.clk       (clk),
		.arst_n    (arst_n),
		.arvalid   (arvalid),
		.araddr    (araddr),
		.arready   (arready),
		.rvalid    (rvalid),
		.rdata     (rdata),
		.rresp     (rresp),
		.rready    (rready),
		.load_en   (load_en),
		.load_addr (load_addr),
		.load_data (load_data)
	);

	next_pc next_pc_inst (
		.clk          (clk),
		.arst_n       (arst_n),
		.inst_valid   (inst_valid),
		.inst         (inst),
		.pc           (pc),
		.fetch_err    (fetch_err),
		.hold         (hold),
		.pc_update    (pc_update),
		.dnpc         (dnpc),
		.retire_valid (retire_valid),
		.retire_pc    (retire_pc),
		.retire_inst  (retire_inst),
		.retire_err   (retire_err)
	);

endmodule

`default_nettype wire

// ==== design/ifu.sv ====
`default_nettype none

module ifu (
	input  wire                           clk,
	input  wire                           arst_n,
	input  wire  [fetch_pkg::xlen-1:0]    dnpc,
	input  wire                           pc_update,
	output logic [fetch_pkg::xlen-1:0]    pc,
	output logic                          arvalid,
	output logic [fetch_pkg::addr_w-1:0]  araddr,
	input  wire                           arready,
	input  wire                           rvalid,
	input  wire  [fetch_pkg::data_w-1:0]  rdata,
	input  wire  [1:0]                    rresp,
	output logic                          rready,
	output logic                          inst_valid,
	output logic [fetch_pkg::inst_w-1:0]  inst,
	output logic                          fetch_err
);
	import fetch_pkg::*;

	// low until the first request after reset went out
	logic boot_done;
	logic ar_fire;
	logic r_fire;

	// no back-pressure on read data
	assign rready = 1'b1;

	assign ar_fire = arvalid && arready;
	assign r_fire = rvalid && rready;

	// request address comes straight from pc
	// pc only moves on pc_update, so it stays put while arvalid waits
	assign araddr = pc[addr_w-1:0];

	// program counter
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pc <= reset_pc;
		end else if (pc_update) begin
			pc <= dnpc;
		end
	end

	// read request
	// first one right after reset, then one per pc_update
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			boot_done <= 1'b0;
			arvalid <= 1'b0;
		end else begin
			if (!boot_done) begin
				boot_done <= 1'b1;
				arvalid <= 1'b1;
			end else if (pc_update) begin
				arvalid <= 1'b1;
			end else if (ar_fire) begin
				// accepted, drop until the next pc
				arvalid <= 1'b0;
			end
		end
	end

	// read data capture
	// pc bit 2 picks the half of the 64-bit word
	always_ff @(posedge clk) begin
		if (r_fire) begin
			if (pc[2]) begin
				inst <= rdata[data_w-1:inst_w];
			end else begin
				inst <= rdata[inst_w-1:0];
			end
		end
	end

	// instruction valid one cycle after read data
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			inst_valid <= 1'b0;
			fetch_err <= 1'b0;
		end else begin
			inst_valid <= r_fire;
			if (r_fire) begin
				// any response but okay counts as a fetch error
				fetch_err <= (rresp != resp_okay);
			end
		end
	end

endmodule

`default_nettype wire

// ==== design/inst_mem.sv ====
`default_nettype none

module inst_mem (
	input  wire                              clk,
	input  wire                              arst_n,
	input  wire                              arvalid,
	input  wire  [fetch_pkg::addr_w-1:0]     araddr,
	output logic                             arready,
	output logic                             rvalid,
	output logic [fetch_pkg::data_w-1:0]     rdata,
	output logic [1:0]                       rresp,
	input  wire                              rready,
	input  wire                              load_en,
	input  wire  [fetch_pkg::mem_idx_w-1:0]  load_addr,
	input  wire  [fetch_pkg::data_w-1:0]     load_data
);
	import fetch_pkg::*;

	logic [data_w-1:0] mem [mem_words];

	// single pending read
	logic pending;
	logic [lat_cnt_w-1:0] lat_cnt;
	logic resp_due;
	logic ar_fire;

	// decoded request, kept until the response goes out
	logic [mem_idx_w-1:0] req_idx;
	logic req_err;

	// address decode
	logic [addr_w-1:0] off;
	logic in_win;
	logic misaligned;

	assign off = araddr - mem_base;
	// below base wraps, so check both ends
	assign in_win = (araddr >= mem_base) && (off[addr_w-1:mem_off_w] == '0);
	assign misaligned = (araddr[1:0] != 2'b00);

	// busy from accept until the data beat is taken
	assign arready = !pending && !rvalid;
	assign ar_fire = arvalid && arready;

	// last counting cycle
	assign resp_due = pending && (lat_cnt == lat_cnt_w'(1));

	// load port
	// works during reset too
	always_ff @(posedge clk) begin
		if (load_en) begin
			mem[load_addr] <= load_data;
		end
	end

	// latch decoded request on accept
	always_ff @(posedge clk) begin
		if (ar_fire) begin
			req_idx <= off[mem_off_w-1:3];
			req_err <= !in_win || misaligned;
		end
	end

	// latency counter and response valid
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pending <= 1'b0;
			lat_cnt <= '0;
			rvalid <= 1'b0;
		end else begin
			if (rvalid && rready) begin
				rvalid <= 1'b0;
			end
			if (ar_fire) begin
				pending <= 1'b1;
				lat_cnt <= lat_cnt_w'(mem_latency - 1);
			end else if (resp_due) begin
				pending <= 1'b0;
				rvalid <= 1'b1;
			end else if (pending) begin
				lat_cnt <= lat_cnt - 1'b1;
			end
		end
	end

	// response payload
	// zero data on slave error
	always_ff @(posedge clk) begin
		if (resp_due) begin
			rdata <= req_err ? '0 : mem[req_idx];
			rresp <= req_err ? resp_slverr : resp_okay;
		end
	end

endmodule

`default_nettype wire

// ==== design/next_pc.sv ====
`default_nettype none

module next_pc (
	input  wire                           clk,
	input  wire                           arst_n,
	input  wire                           inst_valid,
	input  wire  [fetch_pkg::inst_w-1:0]  inst,
	input  wire  [fetch_pkg::xlen-1:0]    pc,
	input  wire                           fetch_err,
	input  wire                           hold,
	output logic                          pc_update,
	output logic [fetch_pkg::xlen-1:0]    dnpc,
	output logic                          retire_valid,
	output logic [fetch_pkg::xlen-1:0]    retire_pc,
	output logic [fetch_pkg::inst_w-1:0]  retire_inst,
	output logic                          retire_err
);
	import fetch_pkg::*;

	// instruction waiting to retire
	logic held;

	// latched fetch result
	rv_inst_u inst_q;
	logic [xlen-1:0] pc_q;
	logic err_q;

	// decode
	logic [xlen-1:0] j_imm;
	logic [xlen-1:0] i_imm;
	logic [xlen-1:0] seq_pc;
	logic is_jal;
	logic is_jalr0;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			held <= 1'b0;
		end else if (inst_valid) begin
			held <= 1'b1;
		end else if (pc_update) begin
			held <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (inst_valid) begin
			inst_q <= inst;
			pc_q <= pc;
			err_q <= fetch_err;
		end
	end

	// j immediate, reassembled and sign extended
	assign j_imm = {{(xlen - 21){inst_q.j_fmt.imm_20}}, inst_q.j_fmt.imm_20,
		inst_q.j_fmt.imm_19_12, inst_q.j_fmt.imm_11, inst_q.j_fmt.imm_10_1, 1'b0};
	// i immediate, sign extended
	assign i_imm = {{(xlen - 12){inst_q.i_fmt.imm_11_0[11]}}, inst_q.i_fmt.imm_11_0};
	assign seq_pc = pc_q + xlen'(4);

	assign is_jal = (inst_q.j_fmt.opcode == op_jal);
	// no register file, so only x0 as base gives a known target
	assign is_jalr0 = (inst_q.i_fmt.opcode == op_jalr) && (inst_q.i_fmt.rs1 == 5'd0);

	// target select, error first
	always_comb begin
		if (err_q) begin
			dnpc = reset_pc;
		end else if (is_jal) begin
			dnpc = pc_q + j_imm;
		end else if (is_jalr0) begin
			dnpc = {i_imm[xlen-1:1], 1'b0};
		end else begin
			dnpc = seq_pc;
		end
	end

	// release once hold drops
	assign pc_update = held && !hold;

	// retire record goes out with the pc update
	assign retire_valid = pc_update;
	assign retire_pc = pc_q;
	assign retire_inst = inst_q;
	assign retire_err = err_q;

endmodule

`default_nettype wire

// ==== list.f ====
design/fetch_pkg.sv
design/ifu.sv
design/inst_mem.sv
design/next_pc.sv
design/fetch_top.sv
verification/fetch_props.sv
verification/fetch_tb.sv

// ==== verification/fetch_props.sv ====
`default_nettype none

module fetch_props (
	input wire                          clk,
	input wire                          arst_n,
	input wire                          arvalid,
	input wire                          arready,
	input wire [fetch_pkg::addr_w-1:0]  araddr,
	input wire                          rvalid,
	input wire                          rready,
	input wire                          pc_update
);

	// read accepted, data not back yet
	logic in_flight;
	// count of failed assertions
	int fail_cnt = 0;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			in_flight <= 1'b0;
		end else if (arvalid && arready) begin
			in_flight <= 1'b1;
		end else if (rvalid && rready) begin
			in_flight <= 1'b0;
		end
	end

	// request waits until accepted
	assert property (@(posedge clk) disable iff (!arst_n)
		arvalid && !arready |=> arvalid)
		else begin
			fail_cnt = fail_cnt + 1;
			$error("arvalid dropped before arready");
		end

	// address held while waiting
	assert property (@(posedge clk) disable iff (!arst_n)
		arvalid && !arready |=> $stable(araddr))
		else begin
			fail_cnt = fail_cnt + 1;
			$error("araddr changed while the request waited");
		end

	// no redirect with a read open
	assert property (@(posedge clk) disable iff (!arst_n)
		pc_update |-> !(arvalid || in_flight))
		else begin
			fail_cnt = fail_cnt + 1;
			$error("pc_update during an outstanding read");
		end

endmodule

bind ifu fetch_props fetch_props_inst (
	.clk       (clk),
	.arst_n    (arst_n),
	.arvalid   (arvalid),
	.arready   (arready),
	.araddr    (araddr),
	.rvalid    (rvalid),
	.rready    (rready),
	.pc_update (pc_update)
);

`default_nettype wire

// ==== verification/fetch_tb.sv ====
`default_nettype none

module fetch_tb;
	import fetch_pkg::*;

	localparam int n_retires = 400;
	localparam int max_cycles = n_retires * (3 + mem_latency + 5) + 50;
	// two instructions per memory word
	localparam int n_slots = mem_words * 2;

	logic clk;
	logic arst_n;
	logic hold;
	logic load_en;
	logic [mem_idx_w-1:0] load_addr;
	logic [data_w-1:0] load_data;
	logic retire_valid;
	logic [xlen-1:0] retire_pc;
	logic [inst_w-1:0] retire_inst;
	logic retire_err;

	// model copy of the program
	logic [data_w-1:0] image [mem_words];

	// reference model state
	logic [xlen-1:0] model_pc;
	logic running;
	logic hold_seen;
	int retire_cnt;
	int cycle_cnt;
	int last_retire_cycle;

	fetch_top fetch_top_inst (
		.clk          (clk),
		.arst_n       (arst_n),
		.hold         (hold),
		.load_en      (load_en),
		.load_addr    (load_addr),
		.load_data    (load_data),
		.retire_valid (retire_valid),
		.retire_pc    (retire_pc),
		.retire_inst  (retire_inst),
		.retire_err   (retire_err)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#4 clk = ~clk;
		end
	end

	task automatic check_equal(input string name, input logic [63:0] expected,
		input logic [63:0] actual);
		if (expected !== actual) begin
			$display("mismatch %s: expected %h, actual %h", name, expected, actual);
			$display("TESTBENCH FAILED");
			$fatal(1, "stopped at first error");
		end
	endtask

	// fetch succeeds only inside the window and 4-byte aligned
	function automatic logic fetch_ok(input logic [xlen-1:0] addr);
		logic [addr_w-1:0] a;
		logic [addr_w-1:0] lo;
		logic [addr_w-1:0] hi;
		a = addr[addr_w-1:0];
		lo = reset_pc[addr_w-1:0];
		hi = lo + addr_w'(mem_words * 8);
		return (a >= lo) && (a < hi) && (a[1:0] == 2'b00);
	endfunction

	// pc bit 2 selects upper half
	function automatic logic [inst_w-1:0] expected_inst(input logic [xlen-1:0] addr);
		logic [addr_w-1:0] off;
		logic [data_w-1:0] word;
		off = addr[addr_w-1:0] - reset_pc[addr_w-1:0];
		word = image[int'(off >> 3)];
		return addr[2] ? word[63:32] : word[31:0];
	endfunction

	// next pc straight from the riscv bit positions
	function automatic logic [xlen-1:0] expected_next(input logic [xlen-1:0] cur,
		input logic [inst_w-1:0] word, input logic err);
		logic [xlen-1:0] imm;
		if (err) begin
			return reset_pc;
		end
		if (word[6:0] == op_jal) begin
			imm = {{43{word[31]}}, word[31], word[19:12], word[20], word[30:21], 1'b0};
			return cur + imm;
		end
		if ((word[6:0] == op_jalr) && (word[19:15] == 5'd0)) begin
			imm = {{52{word[31]}}, word[31:20]};
			return {imm[xlen-1:1], 1'b0};
		end
		return cur + 64'd4;
	endfunction

	// one random instruction for a given slot
	function automatic logic [inst_w-1:0] make_inst(input int slot);
		rv_inst_u w;
		logic [20:0] off;
		int kind;
		int target;
		kind = $urandom_range(0, 99);
		w = $urandom;
		if (kind < 10) begin
			// jal to some slot in the window
			target = $urandom_range(0, n_slots - 1);
			off = 21'((target - slot) * 4);
			if (kind == 0) begin
				// halfword aligned only
				off = off + 21'd2;
			end else if (kind == 1) begin
				// lands past the end
				off = off + 21'(n_slots * 4);
			end
			w.j_fmt.imm_20 = off[20];
			w.j_fmt.imm_10_1 = off[10:1];
			w.j_fmt.imm_11 = off[11];
			w.j_fmt.imm_19_12 = off[19:12];
			w.j_fmt.opcode = op_jal;
		end else if (kind < 16) begin
			// jalr, x0 base lands below the window
			w.i_fmt.opcode = op_jalr;
			w.i_fmt.funct3 = 3'b000;
			if (kind < 13) begin
				w.i_fmt.rs1 = 5'd0;
			end else if (w.i_fmt.rs1 == 5'd0) begin
				w.i_fmt.rs1 = 5'd1;
			end
		end else if ((w.i_fmt.opcode == op_jal) || (w.i_fmt.opcode == op_jalr)) begin
			// plain op-imm instead
			w.i_fmt.opcode = 7'b0010011;
		end
		return w;
	endfunction

	// stimulus, load under reset and then release
	initial begin
		logic [inst_w-1:0] lo_inst;
		logic [inst_w-1:0] hi_inst;
		void'($urandom(32'h9401_078a));
		arst_n = 1'b0;
		hold = 1'b0;
		load_en = 1'b0;
		load_addr = '0;
		load_data = '0;
		running = 1'b0;
		for (int i = 0; i < mem_words; i++) begin
			lo_inst = make_inst(2 * i);
			hi_inst = make_inst(2 * i + 1);
			image[i] = {hi_inst, lo_inst};
		end
		for (int i = 0; i < mem_words; i++) begin
			@(posedge clk);
			#1;
			load_en = 1'b1;
			load_addr = mem_idx_w'(i);
			load_data = image[i];
		end
		@(posedge clk);
		#1;
		load_en = 1'b0;
		// reset still low, 3 more cycles
		repeat (3) @(posedge clk);
		#1;
		arst_n = 1'b1;
		running = 1'b1;
		wait (retire_cnt == n_retires);
		$display("TESTBENCH PASSED");
		$finish;
	end

	// hold bursts of 0 to 4 cycles, always a low cycle between
	initial begin
		int hold_left;
		hold_left = 0;
		wait (running);
		forever begin
			@(posedge clk);
			#1;
			if (hold_left > 0) begin
				hold = 1'b1;
				hold_left = hold_left - 1;
			end else begin
				hold = 1'b0;
				if ($urandom_range(0, 3) == 0) begin
					hold_left = $urandom_range(0, 4);
				end
			end
		end
	end

	// reference model and timeout, sampled at negedge
	initial begin
		logic [inst_w-1:0] exp_inst;
		logic exp_err;
		model_pc = reset_pc;
		retire_cnt = 0;
		cycle_cnt = 0;
		last_retire_cycle = 0;
		hold_seen = 1'b0;
		wait (running);
		forever begin
			@(negedge clk);
			cycle_cnt = cycle_cnt + 1;
			if (cycle_cnt > max_cycles) begin
				$display("timeout: %0d of %0d retires seen after %0d cycles",
					retire_cnt, n_retires, cycle_cnt);
				$display("TESTBENCH FAILED");
				$fatal(1, "run did not finish in time");
			end
			// bound read channel and pc update rules
			if (fetch_top_inst.ifu_inst.fetch_props_inst.fail_cnt != 0) begin
				$display("an assertion in fetch_props failed, see the error above");
				$display("TESTBENCH FAILED");
				$fatal(1, "read channel or pc update rule broken");
			end
			if (hold) begin
				hold_seen = 1'b1;
				check_equal("no retire under hold", 1'b0, retire_valid);
			end
			if (retire_valid) begin
				exp_err = !fetch_ok(model_pc);
				exp_inst = exp_err ? '0 : expected_inst(model_pc);
				check_equal("retire pc", model_pc, retire_pc);
				check_equal("retire err", exp_err, retire_err);
				if (!exp_err) begin
					check_equal("retire inst", exp_inst, retire_inst);
				end
				if (retire_cnt == 0) begin
					check_equal("first pc", reset_pc, retire_pc);
					check_equal("first inst", image[0][31:0], retire_inst);
				end else if (!hold_seen) begin
					// back to back, no stall in between
					check_equal("retire spacing", 3 + mem_latency,
						cycle_cnt - last_retire_cycle);
				end
				model_pc = expected_next(model_pc, exp_inst, exp_err);
				last_retire_cycle = cycle_cnt;
				hold_seen = 1'b0;
				retire_cnt = retire_cnt + 1;
			end
		end
	end

endmodule

`default_nettype wire
